// File: src/fpu_conv_pkg.sv
`default_nettype none

package fpu_conv_pkg;

   localparam int exp_w    = 8;
   localparam int frac_w   = 23;
   localparam int word_w   = 32;
   localparam int exp_bias = 127;

   localparam logic [word_w-1:0] int_max_pos = 32'h7FFF_FFFF; // positive saturation value
   localparam logic [word_w-1:0] int_max_neg = 32'h8000_0000; // negative saturation value

   typedef enum logic {
      op_i2f,
      op_f2i
   } conv_op_t;

   typedef enum logic [1:0] {
      rnd_nearest_even = 2'b00,
      rnd_zero         = 2'b01,
      rnd_up           = 2'b10,
      rnd_down         = 2'b11
   } round_mode_t;

   // class bits of a single-precision operand, several may be set at once
   typedef struct packed {
      logic is_nan;
      logic is_qnan;
      logic is_snan;
      logic is_inf;
      logic is_zero;
      logic is_denorm;
   } fp_class_t;

   typedef struct packed {
      logic invalid;
      logic inexact;
      logic zero;
   } conv_flags_t;

   typedef struct packed {
      conv_op_t          op;
      round_mode_t       rmode;
      logic [word_w-1:0] operand;
   } conv_req_t;

endpackage

`default_nettype wire

// File: src/fpu_conv_except.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_conv_except import fpu_conv_pkg::*; (
   input  logic              clk,
   input  logic [word_w-1:0] operand,
   output fp_class_t         cls
);

   logic [exp_w-1:0]  exp_f;
   logic [frac_w-1:0] frac_f;

   logic exp_ones_q;
   logic exp_zeros_q;
   logic frac_zero_q;
   logic frac_msb_q;

   assign exp_f  = operand[word_w-2 -: exp_w];
   assign frac_f = operand[frac_w-1:0];

   always_ff @(posedge clk) begin
      exp_ones_q  <= &exp_f;
      exp_zeros_q <= ~|exp_f;
      frac_zero_q <= ~|frac_f;
      frac_msb_q  <= frac_f[frac_w-1]; // quiet bit of a NaN
   end

   always_ff @(posedge clk) begin
      cls.is_nan    <= exp_ones_q & ~frac_zero_q;
      cls.is_qnan   <= exp_ones_q & frac_msb_q;
      cls.is_snan   <= exp_ones_q & ~frac_msb_q & ~frac_zero_q;
      cls.is_inf    <= exp_ones_q & frac_zero_q;
      cls.is_zero   <= exp_zeros_q & frac_zero_q; // either sign
      cls.is_denorm <= exp_zeros_q & ~frac_zero_q;
   end

endmodule

`default_nettype wire

// File: src/fpu_i2f.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_i2f import fpu_conv_pkg::*; (
   input  logic              clk,
   input  logic [word_w-1:0] operand,
   input  round_mode_t       rmode,
   output logic [word_w-1:0] result,
   output conv_flags_t       flags
);

   // number of zeros above the leading one, 32 for a zero word
   function automatic logic [5:0] lead_zeros(input logic [word_w-1:0] v);
      logic [5:0] n;
      n = 6'd32;
      for (int i = 0; i < word_w; i++) begin
         if (v[i]) n = 6'(word_w - 1 - i);
      end
      return n;
   endfunction

   logic [word_w-1:0] mag;

   logic              s1_sign;
   logic [word_w-1:0] s1_mag;
   logic [5:0]        s1_lzc;
   round_mode_t       s1_rmode;

   logic [word_w-1:0] norm;
   logic              guard;
   logic              sticky;
   logic              round_inc;
   logic [frac_w+1:0] sig_r;
   logic [exp_w-1:0]  exp_v;
   logic [frac_w-1:0] frac_v;
   logic [word_w-1:0] res_d;
   conv_flags_t       flags_d;

   assign mag = operand[word_w-1] ? -operand : operand; // 80000000 stays as its own magnitude

   always_ff @(posedge clk) begin
      s1_sign  <= operand[word_w-1];
      s1_mag   <= mag;
      s1_lzc   <= lead_zeros(mag);
      s1_rmode <= rmode;
   end

   always_comb begin
      norm   = s1_mag << s1_lzc; // leading one lands in bit 31
      guard  = norm[word_w-frac_w-2];
      sticky = |norm[word_w-frac_w-3:0];

      case (s1_rmode)
         rnd_nearest_even: round_inc = guard & (sticky | norm[word_w-frac_w-1]);
         rnd_zero:         round_inc = 1'b0;
         rnd_up:           round_inc = ~s1_sign & (guard | sticky);
         rnd_down:         round_inc = s1_sign & (guard | sticky);
         default:          round_inc = 1'b0;
      endcase

      sig_r = {1'b0, norm[word_w-1 -: frac_w+1]} + (frac_w+2)'(round_inc);

      // the exponent is 31 minus the leading zeros, plus one on a rounding carry
      exp_v = 8'(exp_bias + word_w - 1) - 8'(s1_lzc) + 8'(sig_r[frac_w+1]);
      frac_v = sig_r[frac_w+1] ? sig_r[frac_w:1] : sig_r[frac_w-1:0];

      flags_d.invalid = 1'b0;
      flags_d.inexact = guard | sticky;
      flags_d.zero    = (s1_mag == '0);

      if (s1_mag == '0) begin
         res_d = '0;
      end else begin
         res_d = {s1_sign, exp_v, frac_v};
      end
   end

   always_ff @(posedge clk) begin
      result <= res_d;
      flags  <= flags_d;
   end

endmodule

`default_nettype wire

// File: src/fpu_f2i.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_f2i import fpu_conv_pkg::*; (
   input  logic              clk,
   input  logic [word_w-1:0] operand,
   input  round_mode_t       rmode,
   input  fp_class_t         cls,
   output logic [word_w-1:0] result,
   output conv_flags_t       flags
);

   logic [exp_w-1:0]      exp_f;
   logic [frac_w:0]       sig;
   logic signed [exp_w:0] exp_unb;
   logic [5:0]            shamt;
   logic [2*word_w-1:0]   aligned;
   logic [word_w-1:0]     int_d;
   logic                  guard_d;
   logic                  sticky_d;
   logic                  oor_d;

   logic                  s1_sign;
   logic signed [exp_w:0] s1_exp;
   logic [word_w-1:0]     s1_int;
   logic                  s1_guard;
   logic                  s1_sticky;
   logic                  s1_oor;
   round_mode_t           s1_rmode;

   logic                  round_inc;
   logic [word_w-1:0]     mag_r;

   logic                  s2_sign;
   logic [word_w-1:0]     s2_res;
   logic                  s2_ovf;
   logic                  s2_inexact;

   assign exp_f   = operand[word_w-2 -: exp_w];
   assign sig     = {(exp_f != '0), operand[frac_w-1:0]}; // hidden bit is clear for denormals
   assign exp_unb = $signed({1'b0, exp_f}) - 9'sd127;

   always_comb begin
      // at or above 2^31, only -2^31 itself fits
      oor_d = (exp_unb >= 9'sd31) &&
              !(operand[word_w-1] && exp_unb == 9'sd31 && operand[frac_w-1:0] == '0);

      shamt = (exp_unb >= 9'sd31) ? 6'd0 : 6'(9'sd31 - exp_unb);
      aligned = {sig, {(2*word_w-frac_w-1){1'b0}}} >> shamt;

      if (exp_unb < -9'sd1) begin
         // below one half, everything lands in sticky
         int_d    = '0;
         guard_d  = 1'b0;
         sticky_d = |sig;
      end else begin
         int_d    = aligned[2*word_w-1:word_w];
         guard_d  = aligned[word_w-1];
         sticky_d = |aligned[word_w-2:0];
      end
   end

   always_ff @(posedge clk) begin
      s1_sign   <= operand[word_w-1];
      s1_exp    <= exp_unb;
      s1_int    <= int_d;
      s1_guard  <= guard_d;
      s1_sticky <= sticky_d;
      s1_oor    <= oor_d;
      s1_rmode  <= rmode;
   end

   always_comb begin
      case (s1_rmode)
         rnd_nearest_even: round_inc = s1_guard & (s1_sticky | s1_int[0]);
         rnd_zero:         round_inc = 1'b0;
         rnd_up:           round_inc = ~s1_sign & (s1_guard | s1_sticky);
         rnd_down:         round_inc = s1_sign & (s1_guard | s1_sticky);
         default:          round_inc = 1'b0;
      endcase
      mag_r = s1_int + word_w'(round_inc);
   end

   always_ff @(posedge clk) begin
      s2_sign    <= s1_sign;
      s2_res     <= s1_sign ? -mag_r : mag_r;
      s2_ovf     <= s1_oor | (s1_exp == 9'sd30 && mag_r[word_w-1] && !s1_sign); // rounded up to 2^31
      s2_inexact <= s1_guard | s1_sticky;
   end

   always_comb begin
      flags  = '0;
      result = s2_res;
      if (cls.is_nan) begin
         result        = int_max_pos;
         flags.invalid = 1'b1;
      end else if (cls.is_inf || s2_ovf) begin
         result        = s2_sign ? int_max_neg : int_max_pos;
         flags.invalid = 1'b1;
      end else begin
         flags.inexact = s2_inexact | cls.is_denorm;
         flags.zero    = cls.is_zero | (s2_res == '0);
      end
   end

endmodule

`default_nettype wire

// File: src/fpu_conv_top.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_conv_top import fpu_conv_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              start,
   input  conv_req_t         req,
   output logic              done,
   output logic [word_w-1:0] result,
   output conv_flags_t       flags
);

   conv_req_t         req_q;
   logic              req_vld;
   conv_op_t          op_pipe [0:1];
   logic [1:0]        vld_pipe;

   fp_class_t         cls;
   logic [word_w-1:0] i2f_result;
   conv_flags_t       i2f_flags;
   logic [word_w-1:0] f2i_result;
   conv_flags_t       f2i_flags;

   always_ff @(posedge clk) begin
      if (start) req_q <= req;
   end

   // valid bits run in step with the two core stages
   always_ff @(posedge clk) begin
      if (rst) begin
         req_vld  <= 1'b0;
         vld_pipe <= '0;
         done     <= 1'b0;
      end else begin
         req_vld  <= start;
         vld_pipe <= {vld_pipe[0], req_vld};
         done     <= vld_pipe[1];
      end
   end

   always_ff @(posedge clk) begin
      op_pipe[0] <= req_q.op;
      op_pipe[1] <= op_pipe[0];
   end

   fpu_conv_except u_except (
      .clk     (clk),
      .operand (req_q.operand),
      .cls     (cls)
   );

   fpu_i2f u_i2f (
      .clk     (clk),
      .operand (req_q.operand),
      .rmode   (req_q.rmode),
      .result  (i2f_result),
      .flags   (i2f_flags)
   );

   fpu_f2i u_f2i (
      .clk     (clk),
      .operand (req_q.operand),
      .rmode   (req_q.rmode),
      .cls     (cls),
      .result  (f2i_result),
      .flags   (f2i_flags)
   );

   always_ff @(posedge clk) begin
      if (op_pipe[1] == op_i2f) begin
         result <= i2f_result;
         flags  <= i2f_flags;
      end else begin
         result <= f2i_result;
         flags  <= f2i_flags;
      end
   end

endmodule

`default_nettype wire

// File: sim/fpu_conv_properties.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_conv_properties import fpu_conv_pkg::*; (
   input logic        clk,
   input logic        rst,
   input logic        start,
   input conv_req_t   req,
   input logic        done,
   input conv_flags_t flags
);

   // nothing can come out while the pipeline is flushed by reset
   assert property (@(posedge clk) ($past(rst) || $past(rst, 2)) |-> !done)
      else $error("done asserted during or just after reset");

   // done is seen four edges after the edge that samples its start
   assert property (@(posedge clk) disable iff (rst) done == $past(start, 4))
      else $error("done does not follow start with the fixed latency");

   assert property (@(posedge clk) disable iff (rst) done |-> !(flags.invalid && flags.zero))
      else $error("invalid and zero flags set together");

   assert property (@(posedge clk) disable iff (rst)
      (done && $past(req.op, 4) == op_i2f) |-> !flags.invalid)
      else $error("invalid flag set on an integer to float conversion");

endmodule

bind fpu_conv_top fpu_conv_properties u_properties (
   .clk   (clk),
   .rst   (rst),
   .start (start),
   .req   (req),
   .done  (done),
   .flags (flags)
);

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clk_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   initial begin
      rst = 1'b1;
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0; // released just after the fifth rising edge
   end

endmodule

`default_nettype wire

// File: sim/fpu_conv_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_conv_tb import fpu_conv_pkg::*; ();

   localparam int rand_pairs = 200;

   typedef struct packed {
      conv_op_t    op;
      round_mode_t rmode;
      logic [31:0] operand;
      logic [31:0] result;
      conv_flags_t flags;
      logic [3:0]  gap; // idle cycles before the next start
   } row_t;

   typedef struct packed {
      logic [31:0] result;
      conv_flags_t flags;
      logic [31:0] cycle;
   } expect_t;

   logic              clk;
   logic              rst;
   logic              start;
   conv_req_t         req;
   logic              done;
   logic [word_w-1:0] result;
   conv_flags_t       flags;

   row_t        rows [$];
   expect_t     exp_q [$];
   logic [31:0] cycle = '0;
   int          n_issued = 0;
   int          n_done = 0;
   logic        table_ready = 1'b0;

   clk_gen u_clk_gen (
      .clk (clk),
      .rst (rst)
   );

   fpu_conv_top DUT (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .req    (req),
      .done   (done),
      .result (result),
      .flags  (flags)
   );

   always @(posedge clk) cycle <= cycle + 32'd1;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR: %s is %h, expected %h", name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1);
      end
   endtask

   task automatic add_row(input conv_op_t op, input round_mode_t rm, input logic [31:0] opnd,
                          input logic [31:0] res, input conv_flags_t fl, input logic [3:0] gap);
      row_t r;
      r.op      = op;
      r.rmode   = rm;
      r.operand = opnd;
      r.result  = res;
      r.flags   = fl;
      r.gap     = gap;
      rows.push_back(r);
   endtask

   // flags are {invalid, inexact, zero}
   task automatic load_table();
      add_row(op_i2f, rnd_nearest_even, 32'h0000_0000, 32'h0000_0000, 3'b001, 4'd0);
      add_row(op_i2f, rnd_nearest_even, 32'h0000_0001, 32'h3F80_0000, 3'b000, 4'd0);
      add_row(op_i2f, rnd_nearest_even, 32'hFFFF_FFFF, 32'hBF80_0000, 3'b000, 4'd1);
      add_row(op_i2f, rnd_nearest_even, 32'h7FFF_FFFF, 32'h4F00_0000, 3'b010, 4'd0);
      add_row(op_i2f, rnd_nearest_even, 32'h8000_0000, 32'hCF00_0000, 3'b000, 4'd2);
      add_row(op_i2f, rnd_nearest_even, 32'h0100_0001, 32'h4B80_0000, 3'b010, 4'd0);
      add_row(op_i2f, rnd_zero,         32'h0100_0001, 32'h4B80_0000, 3'b010, 4'd0);
      add_row(op_i2f, rnd_up,           32'h0100_0001, 32'h4B80_0001, 3'b010, 4'd0);
      add_row(op_i2f, rnd_down,         32'h0100_0001, 32'h4B80_0000, 3'b010, 4'd1);
      add_row(op_f2i, rnd_nearest_even, 32'h3F80_0000, 32'h0000_0001, 3'b000, 4'd0);
      add_row(op_f2i, rnd_nearest_even, 32'hC020_0000, 32'hFFFF_FFFE, 3'b010, 4'd0);
      add_row(op_f2i, rnd_zero,         32'hC020_0000, 32'hFFFF_FFFE, 3'b010, 4'd0);
      add_row(op_f2i, rnd_up,           32'hC020_0000, 32'hFFFF_FFFE, 3'b010, 4'd0);
      add_row(op_f2i, rnd_down,         32'hC020_0000, 32'hFFFF_FFFD, 3'b010, 4'd0);
      add_row(op_f2i, rnd_nearest_even, 32'h3F00_0000, 32'h0000_0000, 3'b011, 4'd3);
      // special operands as one burst of back to back starts
      add_row(op_f2i, rnd_nearest_even, 32'h7FC0_0000, 32'h7FFF_FFFF, 3'b100, 4'd0);
      add_row(op_f2i, rnd_nearest_even, 32'h7F80_0001, 32'h7FFF_FFFF, 3'b100, 4'd0);
      add_row(op_f2i, rnd_nearest_even, 32'h7F80_0000, 32'h7FFF_FFFF, 3'b100, 4'd0);
      add_row(op_f2i, rnd_nearest_even, 32'hFF80_0000, 32'h8000_0000, 3'b100, 4'd0);
      add_row(op_f2i, rnd_zero,         32'h4F00_0000, 32'h7FFF_FFFF, 3'b100, 4'd0);
      add_row(op_f2i, rnd_zero,         32'hCF00_0000, 32'h8000_0000, 3'b000, 4'd0);
      add_row(op_f2i, rnd_nearest_even, 32'h0000_0000, 32'h0000_0000, 3'b001, 4'd0);
      add_row(op_f2i, rnd_nearest_even, 32'h8000_0000, 32'h0000_0000, 3'b001, 4'd0);
      add_row(op_f2i, rnd_zero,         32'h0000_0001, 32'h0000_0000, 3'b011, 4'd0);
      add_row(op_f2i, rnd_up,           32'h0000_0001, 32'h0000_0001, 3'b010, 4'd0);
      add_row(op_f2i, rnd_down,         32'h8000_0001, 32'hFFFF_FFFF, 3'b010, 4'd2);
   endtask

   // single-precision bits of an integer whose magnitude fits in 24 bits
   function automatic logic [31:0] exact_float(input logic [31:0] v);
      logic [31:0] mag;
      logic [31:0] frac;
      int          p;
      mag = v[31] ? -v : v;
      if (mag == 32'd0) return 32'd0;
      p = 0;
      for (int i = 0; i < 24; i++) begin
         if (mag[i]) p = i;
      end
      frac = mag << (23 - p);
      return {v[31], 8'(127 + p), frac[22:0]};
   endfunction

   task automatic issue(input conv_op_t op, input round_mode_t rm, input logic [31:0] opnd,
                        input logic [31:0] res, input conv_flags_t fl);
      expect_t e;
      @(posedge clk);
      #2;
      start       = 1'b1;
      req.op      = op;
      req.rmode   = rm;
      req.operand = opnd;
      e.result    = res;
      e.flags     = fl;
      e.cycle     = cycle;
      exp_q.push_back(e);
      n_issued++;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
         start = 1'b0;
      end
   endtask

   always @(negedge clk) begin : monitor
      expect_t e;
      if (rst) begin
         if (cycle != 32'd0) check("done", 32'(done), 32'h0); // done is reset by the first edge
      end else if (done === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("done arrived with no conversion outstanding");
            $display("RESULT: FAIL");
            $fatal(1);
         end else begin
            e = exp_q.pop_front();
            n_done++;
            check("latency", cycle - e.cycle, 32'd4);
            check("result", result, e.result);
            check("flags", 32'(flags), 32'(e.flags));
         end
      end
   end

   initial begin : watchdog
      int timeout_ns;
      wait (table_ready);
      timeout_ns = (rows.size() + rand_pairs + 20) * 4 * 40;
      #(timeout_ns);
      $display("timeout: the conversions did not all complete in time");
      $display("RESULT: FAIL");
      $fatal(1);
   end

   initial begin : stimulus
      logic [31:0] r;
      logic [31:0] mag;
      logic [31:0] value;
      logic [31:0] fbits;
      round_mode_t rm;
      start = 1'b0;
      req   = '0;
      void'($urandom(45598));
      load_table();
      table_ready = 1'b1;
      @(negedge rst);

      foreach (rows[i]) begin
         issue(rows[i].op, rows[i].rmode, rows[i].operand, rows[i].result, rows[i].flags);
         if (rows[i].gap != 4'd0) idle(int'(rows[i].gap));
      end
      idle(1);

      // i2f in any mode is exact here, and f2i toward zero must give the integer back
      for (int i = 0; i < rand_pairs; i++) begin
         r     = $urandom;
         mag   = r & 32'h00FF_FFFF;
         value = r[31] ? -mag : mag;
         rm    = round_mode_t'(r[25:24]);
         fbits = exact_float(value);
         issue(op_i2f, rm, value, fbits, {2'b00, value == 32'd0});
         issue(op_f2i, rnd_zero, fbits, value, {2'b00, value == 32'd0});
      end
      idle(1);

      // a stray done in these last cycles is caught by the monitor
      while (n_done != n_issued) @(posedge clk);
      repeat (4) @(posedge clk);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
src/fpu_conv_pkg.sv
src/fpu_conv_except.sv
src/fpu_i2f.sv
src/fpu_f2i.sv
src/fpu_conv_top.sv
sim/fpu_conv_properties.sv
sim/clk_gen.sv
sim/fpu_conv_tb.sv

// File: run.sh
#!/bin/sh
# builds the conversion unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f verilog.f --top-module fpu_conv_tb \
   -Mdir obj_dir -o fpu_conv_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/fpu_conv_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

echo "simulation finished"
exit 0
